// ==== Bender.yml ====
package:
  name: wbu

export_include_dirs:
  - include

sources:
  - files:
      - design/wbu_pkg.sv
      - design/wb_result_mux.sv
      - design/gpr_file.sv
      - design/csr_file.sv
      - design/wbu.sv
  - target: test
    files:
      - test/wbu_assertions.sv
      - test/wbu_tb.sv

// ==== design/csr_file.sv ====
`timescale 1ns/100ps
`include "wbu_consts.svh"

module csr_file (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wbu_receive_valid,
  input  wbu_pkg::csr_idx_t    csr_rs,
  input  wbu_pkg::csr_idx_t    csr_rd,
  input  logic [`WBU_XLEN-1:0] csr_wd,
  input  logic                 csreg_write_en,
  input  logic                 ecall,
  input  logic [`WBU_XLEN-1:0] ecall_src_data,
  input  logic [`WBU_XLEN-1:0] pc_next_input,
  output logic [`WBU_XLEN-1:0] csra
);
  import wbu_pkg::*;

  logic [`WBU_XLEN-1:0] csr_q [`WBU_NUM_CSR];
  logic [`WBU_XLEN-1:0] csr_d [`WBU_NUM_CSR];
  logic                 sw_wr;
  logic                 trap_wr;

  assign sw_wr   = wbu_receive_valid && csreg_write_en;
  assign trap_wr = wbu_receive_valid && ecall;

  // Next value per slot
  always_comb begin
    for (int i = 0; i < `WBU_NUM_CSR; i++) begin
      csr_d[i] = csr_q[i];
      if (sw_wr && (csr_rd == csr_idx_t'(i))) begin
        csr_d[i] = csr_wd;
      end
    end
    if (trap_wr) begin
      csr_d[CSR_MCAUSE] = ecall_src_data; // Ecall outranks the software write
      csr_d[CSR_MEPC]   = pc_next_input;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `WBU_NUM_CSR; i++) begin
        csr_q[i] <= '0;
      end
    end else if (wbu_receive_valid) begin
      for (int i = 0; i < `WBU_NUM_CSR; i++) begin
        csr_q[i] <= csr_d[i];
      end
    end
  end

  assign csra = csr_q[csr_rs]; // Old value on a same-cycle write

endmodule

// ==== design/gpr_file.sv ====
`timescale 1ns/100ps
`include "wbu_consts.svh"

module gpr_file (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wbu_receive_valid,
  input  logic [`WBU_GPR_AW-1:0] rs1,
  input  logic [`WBU_GPR_AW-1:0] rs2,
  input  logic [`WBU_GPR_AW-1:0] rd,
  input  logic [`WBU_XLEN-1:0]   wd,
  input  logic                   reg_write_en,
  output logic [`WBU_XLEN-1:0]   rsa,
  output logic [`WBU_XLEN-1:0]   rsb,
  output logic [`WBU_XLEN-1:0]   ecall_src_data
);

  // x0 has no storage
  logic [`WBU_XLEN-1:0] regs [`WBU_NUM_GPR-1:1];
  logic                 wr_fire;
  logic [`WBU_XLEN-1:0] rd_a;
  logic [`WBU_XLEN-1:0] rd_b;

  assign wr_fire = wbu_receive_valid && reg_write_en && (rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `WBU_NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire) begin
      regs[rd] <= wd;
    end
  end

  // Port A
  always_comb begin
    if (rs1 == '0) begin
      rd_a = '0;
    end else begin
      rd_a = regs[rs1];
    end
  end

  // Port B
  always_comb begin
    if (rs2 == '0) begin
      rd_b = '0;
    end else begin
      rd_b = regs[rs2];
    end
  end

  assign rsa = rd_a;
  assign rsb = rd_b;

  // Holds the old a5 until this commit's own write lands
  assign ecall_src_data = regs[`WBU_ECALL_SRC];

endmodule

// ==== design/wb_result_mux.sv ====
`timescale 1ns/100ps
`include "wbu_consts.svh"

module wb_result_mux (
  input  wbu_pkg::wb_sel_t     wb_sel,
  input  wbu_pkg::load_kind_t  load_kind,
  input  logic [`WBU_XLEN-1:0] alu_result,
  input  logic [`WBU_XLEN-1:0] mem_rdata,
  input  logic [`WBU_XLEN-1:0] pc_next_input,
  output logic [`WBU_XLEN-1:0] wd
);
  import wbu_pkg::*;

  logic [1:0]           byte_off;
  logic [7:0]           load_byte;
  logic [15:0]          load_half;
  logic [`WBU_XLEN-1:0] load_data;
  logic [`WBU_XLEN-1:0] link_addr;

  assign byte_off  = alu_result[1:0]; // Low address bits of the load
  assign load_byte = mem_rdata[{byte_off, 3'b000} +: 8];
  assign load_half = mem_rdata[{byte_off[1], 4'b0000} +: 16]; // Bit 0 ignored for halves

  assign link_addr = pc_next_input + `WBU_XLEN'(4);

  always_comb begin
    case (load_kind)
      LD_B: begin
        load_data = {{(`WBU_XLEN-8){load_byte[7]}}, load_byte};
      end
      LD_H: begin
        load_data = {{(`WBU_XLEN-16){load_half[15]}}, load_half};
      end
      LD_BU: begin
        load_data = {{(`WBU_XLEN-8){1'b0}}, load_byte};
      end
      LD_HU: begin
        load_data = {{(`WBU_XLEN-16){1'b0}}, load_half};
      end
      default: begin
        load_data = mem_rdata; // Word loads and unknown funct3
      end
    endcase
  end

  always_comb begin
    case (wb_sel)
      WB_LOAD: begin
        wd = load_data;
      end
      WB_LINK: begin
        wd = link_addr;
      end
      default: begin
        wd = alu_result;
      end
    endcase
  end

endmodule

// ==== design/wbu.sv ====
`timescale 1ns/100ps
`include "wbu_consts.svh"

module wbu (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wbu_receive_valid,
  input  logic [`WBU_GPR_AW-1:0] rs1,
  input  logic [`WBU_GPR_AW-1:0] rs2,
  input  logic [`WBU_GPR_AW-1:0] rd,
  input  wbu_pkg::csr_idx_t      csr_rs,
  input  wbu_pkg::csr_idx_t      csr_rd,
  input  wbu_pkg::wb_sel_t       wb_sel,
  input  wbu_pkg::load_kind_t    load_kind,
  input  logic [`WBU_XLEN-1:0]   alu_result,
  input  logic [`WBU_XLEN-1:0]   mem_rdata,
  input  logic [`WBU_XLEN-1:0]   csr_wd,
  input  logic                   reg_write_en,
  input  logic                   csreg_write_en,
  input  logic                   ecall,
  input  logic [`WBU_XLEN-1:0]   pc_next_input,
  output logic [`WBU_XLEN-1:0]   rsa,
  output logic [`WBU_XLEN-1:0]   rsb,
  output logic [`WBU_XLEN-1:0]   csra,
  output logic [`WBU_XLEN-1:0]   commit_pc
);

  logic [`WBU_XLEN-1:0] wd;
  logic [`WBU_XLEN-1:0] ecall_src_data;
  logic [`WBU_XLEN-1:0] pc_q;

  // The committed next-PC advances once per retired instruction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= `WBU_RESET_PC;
    end else if (wbu_receive_valid) begin
      pc_q <= pc_next_input;
    end
  end

  assign commit_pc = pc_q;

  wb_result_mux wb_result_mux_i (
    .wb_sel        (wb_sel),
    .load_kind     (load_kind),
    .alu_result    (alu_result),
    .mem_rdata     (mem_rdata),
    .pc_next_input (pc_next_input),
    .wd            (wd)
  );

  gpr_file gpr_file_i (
    .clk               (clk),
    .arst_n            (arst_n),
    .wbu_receive_valid (wbu_receive_valid),
    .rs1               (rs1),
    .rs2               (rs2),
    .rd                (rd),
    .wd                (wd),
    .reg_write_en      (reg_write_en),
    .rsa               (rsa),
    .rsb               (rsb),
    .ecall_src_data    (ecall_src_data)
  );

  // mepc takes the PC of the committing ecall
  csr_file csr_file_i (
    .clk               (clk),
    .arst_n            (arst_n),
    .wbu_receive_valid (wbu_receive_valid),
    .csr_rs            (csr_rs),
    .csr_rd            (csr_rd),
    .csr_wd            (csr_wd),
    .csreg_write_en    (csreg_write_en),
    .ecall             (ecall),
    .ecall_src_data    (ecall_src_data),
    .pc_next_input     (pc_next_input),
    .csra              (csra)
  );

endmodule

// ==== design/wbu_pkg.sv ====
`include "wbu_consts.svh"

package wbu_pkg;

  // The unused writeback source code falls back to the ALU result
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LOAD = 2'd1,
    WB_LINK = 2'd2
  } wb_sel_t;

  // RV32 load funct3 encodings
  typedef enum logic [2:0] {
    LD_B  = 3'b000,
    LD_H  = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_kind_t;

  // CSR slot numbers
  typedef enum logic [`WBU_CSR_AW-1:0] {
    CSR_MCAUSE  = `WBU_CSR_AW'(0),
    CSR_MEPC    = `WBU_CSR_AW'(1),
    CSR_MSTATUS = `WBU_CSR_AW'(2),
    CSR_MTVEC   = `WBU_CSR_AW'(3)
  } csr_idx_t;

endpackage

// ==== include/wbu_consts.svh ====
`ifndef WBU_CONSTS_SVH
`define WBU_CONSTS_SVH

// Datapath width of the core
`define WBU_XLEN 32

// General register file geometry
`define WBU_NUM_GPR 32
`define WBU_GPR_AW 5

// Machine CSR slots for mcause, mepc, mstatus and mtvec
`define WBU_NUM_CSR 4
`define WBU_CSR_AW 2

// a5 is copied into mcause on ecall
`define WBU_ECALL_SRC 15

// Commit PC after reset
`define WBU_RESET_PC 32'h0000_0000

`endif

// ==== test/wbu_assertions.sv ====
`timescale 1ns/100ps
`include "wbu_consts.svh"

module wbu_assertions (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   wbu_receive_valid,
  input logic [`WBU_GPR_AW-1:0] rs1,
  input logic [`WBU_XLEN-1:0]   rsa,
  input wbu_pkg::csr_idx_t      csr_rs,
  input logic [`WBU_XLEN-1:0]   csra,
  input logic [`WBU_XLEN-1:0]   commit_pc
);

  int fail_count = 0;

  // x0 has no storage and must always read zero
  x0_reads_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    (rs1 == '0) |-> (rsa == '0)
  ) else begin
    fail_count++;
    $error("rsa is nonzero while rs1 selects x0");
  end

  pc_holds_without_commit: assert property (
    @(posedge clk) disable iff (!arst_n)
    !wbu_receive_valid |=> $stable(commit_pc)
  ) else begin
    fail_count++;
    $error("commit_pc changed after a cycle without a commit");
  end

  // Same CSR address and no commit in between, so the read data cannot move
  csra_holds_without_commit: assert property (
    @(posedge clk) disable iff (!arst_n)
    (!wbu_receive_valid ##1 $stable(csr_rs)) |-> $stable(csra)
  ) else begin
    fail_count++;
    $error("csra changed without a commit while csr_rs was held");
  end

endmodule

bind wbu wbu_assertions wbu_assertions_i (.*);

// ==== test/wbu_tb.sv ====
`timescale 1ns/100ps
`include "wbu_consts.svh"

module wbu_tb;
  import wbu_pkg::*;

  logic                   clk;
  logic                   arst_n;
  logic                   wbu_receive_valid;
  logic [`WBU_GPR_AW-1:0] rs1;
  logic [`WBU_GPR_AW-1:0] rs2;
  logic [`WBU_GPR_AW-1:0] rd;
  csr_idx_t               csr_rs;
  csr_idx_t               csr_rd;
  wb_sel_t                wb_sel;
  load_kind_t             load_kind;
  logic [`WBU_XLEN-1:0]   alu_result;
  logic [`WBU_XLEN-1:0]   mem_rdata;
  logic [`WBU_XLEN-1:0]   csr_wd;
  logic                   reg_write_en;
  logic                   csreg_write_en;
  logic                   ecall;
  logic [`WBU_XLEN-1:0]   pc_next_input;
  logic [`WBU_XLEN-1:0]   rsa;
  logic [`WBU_XLEN-1:0]   rsb;
  logic [`WBU_XLEN-1:0]   csra;
  logic [`WBU_XLEN-1:0]   commit_pc;

  // Reference state
  logic [`WBU_XLEN-1:0] model_gpr [`WBU_NUM_GPR];
  logic [`WBU_XLEN-1:0] model_csr [`WBU_NUM_CSR];
  logic [`WBU_XLEN-1:0] model_pc;

  logic [15:0] lfsr_state = 16'd58868;
  int          err_count;
  int          check_count;
  int          tests_passed;
  int          tests_failed;
  int          test_err_base;

  wbu wbu_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_next_bit();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out_bit;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_next_bit()};
    end
    return val;
  endfunction

  function automatic logic [31:0] model_wd(input wb_sel_t sel, input load_kind_t kind,
      input logic [31:0] alu, input logic [31:0] mem, input logic [31:0] pc);
    logic [31:0] by;
    logic [31:0] hw;
    by = mem >> (8 * alu[1:0]); // Byte lane picked by the address
    hw = mem >> (16 * alu[1]);
    if (sel == WB_LINK) begin
      return pc + 32'd4;
    end
    if (sel != WB_LOAD) begin
      return alu;
    end
    case (kind)
      LD_B:    return {{24{by[7]}}, by[7:0]};
      LD_H:    return {{16{hw[15]}}, hw[15:0]};
      LD_BU:   return {24'h0, by[7:0]};
      LD_HU:   return {16'h0, hw[15:0]};
      default: return mem;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    if (err_count == test_err_base) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = wbu_i.wbu_assertions_i.fail_count;
    $display("tests passed %0d, failed %0d; checks %0d, errors %0d, assertion failures %0d",
             tests_passed, tests_failed, check_count, err_count, assert_fails);
    if (tests_failed == 0 && err_count == 0 && assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  task automatic commit(input wb_sel_t sel, input load_kind_t kind, input logic [31:0] alu,
      input logic [31:0] mem, input logic [31:0] pc, input logic [4:0] dst,
      input logic gpr_we, input csr_idx_t cdst, input logic [31:0] cdata,
      input logic csr_we, input logic do_ecall);
    logic [31:0] old_a5;
    @(posedge clk);
    wb_sel <= sel;
    load_kind <= kind;
    alu_result <= alu;
    mem_rdata <= mem;
    pc_next_input <= pc;
    rd <= dst;
    reg_write_en <= gpr_we;
    csr_rd <= cdst;
    csr_wd <= cdata;
    csreg_write_en <= csr_we;
    ecall <= do_ecall;
    wbu_receive_valid <= 1'b1;
    @(posedge clk);
    wbu_receive_valid <= 1'b0;
    reg_write_en <= 1'b0;
    csreg_write_en <= 1'b0;
    ecall <= 1'b0;
    old_a5 = model_gpr[`WBU_ECALL_SRC]; // Ecall sees a5 from before this commit
    if (csr_we) begin
      model_csr[cdst] = cdata;
    end
    if (do_ecall) begin
      model_csr[CSR_MCAUSE] = old_a5;
      model_csr[CSR_MEPC] = pc;
    end
    if (gpr_we && dst != 5'd0) begin
      model_gpr[dst] = model_wd(sel, kind, alu, mem, pc);
    end
    model_pc = pc;
    @(negedge clk);
    check_value("commit_pc", model_pc, commit_pc);
  endtask

  task automatic read_gprs(input logic [4:0] a, input logic [4:0] b);
    @(posedge clk);
    rs1 <= a;
    rs2 <= b;
    @(negedge clk);
    check_value($sformatf("rsa (x%0d)", a), model_gpr[a], rsa);
    check_value($sformatf("rsb (x%0d)", b), model_gpr[b], rsb);
  endtask

  task automatic read_csr(input csr_idx_t idx);
    @(posedge clk);
    csr_rs <= idx;
    @(negedge clk);
    check_value($sformatf("csra (slot %0d)", idx), model_csr[idx], csra);
  endtask

  task automatic check_all_state();
    for (int i = 0; i < `WBU_NUM_GPR / 2; i++) begin
      read_gprs(`WBU_GPR_AW'(i), `WBU_GPR_AW'(`WBU_NUM_GPR - 1 - i));
    end
    for (int c = 0; c < `WBU_NUM_CSR; c++) begin
      read_csr(csr_idx_t'(c));
    end
    check_value("commit_pc", model_pc, commit_pc);
  endtask

  // All enables up, strobe low, random payloads
  task automatic hold_without_strobe(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      wbu_receive_valid <= 1'b0;
      reg_write_en <= 1'b1;
      csreg_write_en <= 1'b1;
      ecall <= 1'b1;
      rd <= `WBU_GPR_AW'(random_bits(5));
      csr_rd <= csr_idx_t'(2'(random_bits(2)));
      wb_sel <= wb_sel_t'(2'(random_bits(2)));
      alu_result <= random_bits(32);
      mem_rdata <= random_bits(32);
      csr_wd <= random_bits(32);
      pc_next_input <= random_bits(32);
    end
    @(posedge clk);
    reg_write_en <= 1'b0;
    csreg_write_en <= 1'b0;
    ecall <= 1'b0;
  endtask

  initial begin
    logic [`WBU_GPR_AW-1:0] dst;
    logic [`WBU_GPR_AW-1:0] ra;
    logic [`WBU_GPR_AW-1:0] rb;
    logic [31:0]            val;
    logic [31:0]            mem;
    logic [31:0]            pc;
    logic [31:0]            a5_val;
    wb_sel_t                sel;
    load_kind_t             kind;
    csr_idx_t               slot;

    arst_n <= 1'b0;
    wbu_receive_valid <= 1'b0;
    rs1 <= '0;
    rs2 <= '0;
    rd <= '0;
    csr_rs <= CSR_MCAUSE;
    csr_rd <= CSR_MCAUSE;
    wb_sel <= WB_ALU;
    load_kind <= LD_W;
    alu_result <= '0;
    mem_rdata <= '0;
    csr_wd <= '0;
    reg_write_en <= 1'b0;
    csreg_write_en <= 1'b0;
    ecall <= 1'b0;
    pc_next_input <= '0;
    for (int i = 0; i < `WBU_NUM_GPR; i++) begin
      model_gpr[i] = '0;
    end
    for (int i = 0; i < `WBU_NUM_CSR; i++) begin
      model_csr[i] = '0;
    end
    model_pc = `WBU_RESET_PC;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    check_all_state();
    end_test("reset state");

    for (int n = 0; n < 300; n++) begin
      dst = `WBU_GPR_AW'(random_bits(5)); // x0 is a legal target here
      val = random_bits(32);
      pc = random_bits(32) & 32'hFFFF_FFFC;
      commit(WB_ALU, LD_W, val, '0, pc, dst, 1'b1, CSR_MSTATUS, '0, 1'b0, 1'b0);
      ra = `WBU_GPR_AW'(random_bits(5));
      rb = `WBU_GPR_AW'(random_bits(5));
      read_gprs(ra, rb);
    end
    read_gprs('0, '0);
    end_test("random register traffic");

    for (int n = 0; n < 200; n++) begin
      sel = wb_sel_t'(2'(random_bits(2)));
      kind = load_kind_t'(3'(random_bits(3)));
      val = random_bits(32);
      mem = random_bits(32);
      pc = random_bits(32) & 32'hFFFF_FFFC;
      dst = `WBU_GPR_AW'(random_bits(5) % 31 + 1);
      commit(sel, kind, val, mem, pc, dst, 1'b1, CSR_MSTATUS, '0, 1'b0, 1'b0);
      read_gprs(dst, dst);
      check_value("commit_pc", pc, commit_pc);
    end
    end_test("result selection and load extension");

    for (int n = 0; n < 60; n++) begin
      slot = csr_idx_t'(2'(random_bits(2)));
      val = random_bits(32);
      pc = random_bits(32) & 32'hFFFF_FFFC;
      commit(WB_ALU, LD_W, '0, '0, pc, '0, 1'b0, slot, val, 1'b1, 1'b0);
      read_csr(csr_idx_t'(2'(random_bits(2))));
    end
    for (int c = 0; c < `WBU_NUM_CSR; c++) begin
      read_csr(csr_idx_t'(c));
    end
    end_test("CSR writes");

    for (int n = 0; n < 16; n++) begin
      a5_val = random_bits(32);
      pc = random_bits(32) & 32'hFFFF_FFFC;
      commit(WB_ALU, LD_W, a5_val, '0, pc, `WBU_GPR_AW'(`WBU_ECALL_SRC), 1'b1,
             CSR_MSTATUS, '0, 1'b0, 1'b0);
      slot = random_bits(1) ? CSR_MEPC : CSR_MCAUSE;
      val = random_bits(32);
      mem = random_bits(32);
      pc = random_bits(32) & 32'hFFFF_FFFC;
      // Same commit writes a CSR, rewrites a5 and raises ecall
      commit(WB_ALU, LD_W, mem, '0, pc, `WBU_GPR_AW'(`WBU_ECALL_SRC), 1'b1,
             slot, val, 1'b1, 1'b1);
      read_csr(CSR_MCAUSE);
      check_value("csra (mcause from old a5)", a5_val, csra);
      read_csr(CSR_MEPC);
      check_value("csra (mepc)", pc, csra);
      read_gprs(`WBU_GPR_AW'(`WBU_ECALL_SRC), `WBU_GPR_AW'(`WBU_ECALL_SRC));
    end
    end_test("ecall capture and priority");

    hold_without_strobe(24);
    check_all_state();
    end_test("no commit without strobe");

    finish_run();
  end

endmodule

// ==== vlog.f ====
+incdir+include
design/wbu_pkg.sv
design/wb_result_mux.sv
design/gpr_file.sv
design/csr_file.sv
design/wbu.sv
test/wbu_assertions.sv
test/wbu_tb.sv
